//--- list.f
+incdir+verif
rtl/cpu_decode_pkg.sv
rtl/cycle_timer.sv
rtl/instr_reg.sv
rtl/op_decoder.sv
rtl/strobe_gen.sv
rtl/decode_top.sv
verif/decode_tb.sv

//--- verif/decode_vectors.svh
// Each row holds opcode, second byte, counts (m rd wr inc go wen) and
// fields (rd_addr wr_addr src alu_op alu_src bit_index misc addr), one hex digit each
typedef struct packed {
    logic [3:0] m;    // M-cycles
    logic [3:0] rd;   // Bus reads, opcode fetch included
    logic [3:0] wr;
    logic [3:0] inc;  // inc_pc pulses
    logic [3:0] go;
    logic [3:0] wen;  // Clocks with wr_en high
} cnt_t;

typedef struct packed {
    logic [3:0] rd_addr;    // F when the read port is never enabled
    logic [3:0] wr_addr;
    logic [3:0] src;
    logic [3:0] alu_op;
    logic [3:0] alu_src;
    logic [3:0] bit_index;
    logic [3:0] misc;       // Bit 1 incdec, bit 0 misc
    logic [3:0] addr;       // Address select at the first bus pulse
} fld_t;

typedef struct packed {
    logic [7:0] opcode;
    logic [7:0] byte2;
    cnt_t       cnt;
    fld_t       fld;
} vec_t;

localparam int NUM_VEC = 25;

localparam vec_t VECTORS [NUM_VEC] = '{
    '{8'h00, 8'h00, 24'h110000, 32'hF0000000},  // NOP
    '{8'h78, 8'h00, 24'h110002, 32'h07000000},  // LD A,B
    '{8'h4D, 8'h00, 24'h110002, 32'h51000000},  // LD C,L
    '{8'h04, 8'h00, 24'h110012, 32'h00140020},  // INC B
    '{8'h3D, 8'h00, 24'h110012, 32'h77150020},  // DEC A
    '{8'h46, 8'h00, 24'h220002, 32'hF0200006},  // LD B,(HL)
    '{8'h7E, 8'h00, 24'h220002, 32'hF7200006},  // LD A,(HL)
    '{8'h71, 8'h00, 24'h211000, 32'h10000006},  // LD (HL),C
    '{8'h0E, 8'h5A, 24'h220102, 32'hF1200000},  // LD C,n
    '{8'h3E, 8'h80, 24'h220102, 32'hF7200000},  // LD A,n
    '{8'h01, 8'h34, 24'h330204, 32'hF1200000},  // LD BC,nn, low byte to C
    '{8'h11, 8'h12, 24'h330204, 32'hF3200000},  // LD DE,nn
    '{8'h21, 8'hFF, 24'h330204, 32'hF5200000},  // LD HL,nn
    '{8'h80, 8'h00, 24'h110012, 32'h07100000},  // ADD A,B
    '{8'hA9, 8'h00, 24'h110012, 32'h17150000},  // XOR C
    '{8'hBE, 8'h00, 24'h220012, 32'h77171006},  // CP (HL)
    '{8'h96, 8'h00, 24'h220012, 32'h77121006},  // SUB (HL)
    '{8'hC6, 8'h11, 24'h220112, 32'h77101000},  // ADD A,n
    '{8'hEE, 8'h0F, 24'h220112, 32'h77151000},  // XOR n
    '{8'hCB, 8'h00, 24'h220112, 32'h00100000},  // RLC B
    '{8'hCB, 8'h3F, 24'h220112, 32'h77170000},  // SRL A
    '{8'hCB, 8'h7A, 24'h220110, 32'h20010710},  // BIT 7,D
    '{8'hCB, 8'h9C, 24'h220112, 32'h44120310},  // RES 3,H
    '{8'hCB, 8'hE9, 24'h220112, 32'h11130510},  // SET 5,C
    '{8'h76, 8'h00, 24'h110000, 32'hF0000000}   // HALT is not kept, runs as NOP
};

//--- verif/decode_tb.sv
module decode_tb;

    localparam int LIMIT    = 40;  // Clocks allowed for one instruction
    localparam int NUM_RAND = 40;

    logic                      clk;
    logic                      rst;
    logic [7:0]                data_bus_in;
    cpu_decode_pkg::reg_ctrl_t reg_ctrl;
    cpu_decode_pkg::alu_ctrl_t alu_ctrl;
    cpu_decode_pkg::bus_ctrl_t bus_ctrl;
    logic                      ext;
    logic                      hold;
    logic                      m1t1;
    logic [1:0]                m_cycle;
    logic [1:0]                t_cycle;

    int   errors;
    int   tests;
    logic hung;      // An instruction never reached the next m1t1
    int   order[$];  // Row indices in run order

    `include "decode_vectors.svh"

    decode_top dut0 (
        .clk         (clk),
        .rst         (rst),
        .data_bus_in (data_bus_in),
        .reg_ctrl    (reg_ctrl),
        .alu_ctrl    (alu_ctrl),
        .bus_ctrl    (bus_ctrl),
        .ext         (ext),
        .hold        (hold),
        .m1t1        (m1t1),
        .m_cycle     (m_cycle),
        .t_cycle     (t_cycle)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic report_mismatch(input string msg);
        $display("CHECK FAILED at %0t: %s", $time, msg);
        errors++;
    endtask

    // Reset values, then the NOP that runs right after reset
    task automatic check_reset(input logic [7:0] first_op);
        int n;
        for (n = 0; n < 10; n++) begin
            @(negedge clk);
            if (!hold || bus_ctrl.rd || bus_ctrl.wr || reg_ctrl.wr_en || alu_ctrl.go ||
                reg_ctrl.inc_pc) begin
                report_mismatch("hold low or strobe active during reset");
            end
        end
        @(posedge clk);
        rst <= 1'b1;
        for (n = 1; n <= 5; n++) begin
            @(negedge clk);
            if (m1t1 != (n == 1 || n == 5)) begin
                report_mismatch($sformatf("m1t1 is %b in clock %0d after reset", m1t1, n));
            end
            if (hold != (n <= 4)) begin
                report_mismatch($sformatf("hold is %b in clock %0d after reset", hold, n));
            end
            if (n == 1 && (bus_ctrl.rd || bus_ctrl.wr || reg_ctrl.wr_en || alu_ctrl.go ||
                           reg_ctrl.inc_pc)) begin
                report_mismatch("strobe active in the first clock after reset");
            end
            if (n == 4) begin
                @(posedge clk);
                data_bus_in <= first_op;  // Ready for the next opcode capture
            end
        end
    endtask

    // Entered at the negedge of the row's m1t1 clock, left at the next one
    task automatic run_instr(input vec_t v, input logic [7:0] next_op);
        cnt_t seen;
        fld_t got;
        int   cycles;
        int   ext_cycles;
        logic done;
        logic last_t4;
        logic bus_pulse;
        logic got_rd_en;
        logic got_wen;
        logic got_go;
        logic got_bus;

        seen        = '0;
        got         = '0;
        got.rd_addr = 4'hF;
        cycles      = 1;
        ext_cycles  = 0;
        done        = 1'b0;
        got_rd_en   = 1'b0;
        got_wen     = 1'b0;
        got_go      = 1'b0;
        got_bus     = 1'b0;
        @(posedge clk);
        data_bus_in <= v.byte2;  // Extension byte or immediate
        while (!done && cycles <= LIMIT) begin
            @(negedge clk);
            if (m1t1) begin
                done = 1'b1;
            end else begin
                cycles++;
                // Clock count since m1t1 gives the M- and T-cycle
                if (t_cycle != 2'((cycles - 1) % 4) || m_cycle != 2'((cycles - 1) / 4)) begin
                    report_mismatch($sformatf("m_cycle %0d t_cycle %0d in clock %0d of %h",
                                              m_cycle, t_cycle, cycles, v.opcode));
                end
                if (reg_ctrl.writeback != (cycles % 4 == 0)) begin
                    report_mismatch($sformatf("writeback is %b in clock %0d of %h",
                                              reg_ctrl.writeback, cycles, v.opcode));
                end
                bus_pulse = bus_ctrl.rd || bus_ctrl.wr;
                if (bus_ctrl.rd && bus_ctrl.wr) begin
                    report_mismatch("bus rd and wr high together");
                end
                if ((bus_pulse || alu_ctrl.go) && t_cycle != 2'd2) begin
                    report_mismatch($sformatf("rd, wr or go high at T%0d", t_cycle + 1));
                end
                if ((reg_ctrl.wr_en && !t_cycle[1]) || (reg_ctrl.inc_pc && t_cycle != 2'd0)) begin
                    report_mismatch($sformatf("wr_en or inc_pc high at T%0d", t_cycle + 1));
                end
                if ((bus_pulse && !reg_ctrl.drive_addr) || hold) begin
                    report_mismatch("address not driven on a bus pulse, or hold still high");
                end
                if (reg_ctrl.rd_en && !got_rd_en) begin
                    got_rd_en   = 1'b1;
                    got.rd_addr = {1'b0, reg_ctrl.rd_addr};
                end
                if (reg_ctrl.wr_en && !got_wen) begin
                    got_wen     = 1'b1;
                    got.wr_addr = {1'b0, reg_ctrl.wr_addr};
                    got.src     = {2'b00, reg_ctrl.src_sel};
                end
                if (alu_ctrl.go && !got_go) begin
                    got_go        = 1'b1;
                    got.alu_op    = {1'b0, alu_ctrl.op};
                    got.alu_src   = {3'b000, alu_ctrl.src_sel};
                    got.bit_index = {1'b0, alu_ctrl.bit_index};
                    got.misc      = {2'b00, alu_ctrl.incdec, alu_ctrl.misc};
                end
                if (bus_pulse && !got_bus) begin
                    got_bus  = 1'b1;
                    got.addr = {1'b0, reg_ctrl.mem_addr_sel};
                end
                seen.rd  += 4'(bus_ctrl.rd);
                seen.wr  += 4'(bus_ctrl.wr);
                seen.inc += 4'(reg_ctrl.inc_pc);
                seen.go  += 4'(alu_ctrl.go);
                seen.wen += 4'(reg_ctrl.wr_en);
                ext_cycles += int'(ext);
                last_t4 = (t_cycle == 2'd3) && (m_cycle == 2'(v.cnt.m - 4'd1));
                @(posedge clk);
                if (last_t4) begin
                    data_bus_in <= next_op;
                end
            end
        end
        if (!done) begin
            $display("TIMEOUT at %0t: opcode %h %h did not reach the next m1t1 in %0d clocks",
                     $time, v.opcode, v.byte2, LIMIT);
            errors++;
            hung = 1'b1;
        end else begin
            seen.m = 4'(cycles / 4);
            if (cycles != 4 * v.cnt.m) begin
                report_mismatch($sformatf("opcode %h %h took %0d clocks, expected %0d",
                                          v.opcode, v.byte2, cycles, 4 * v.cnt.m));
            end
            if (seen != v.cnt) begin
                report_mismatch($sformatf("opcode %h %h counts %h, expected %h",
                                          v.opcode, v.byte2, seen, v.cnt));
            end
            if (got != v.fld) begin
                report_mismatch($sformatf("opcode %h %h fields %h, expected %h",
                                          v.opcode, v.byte2, got, v.fld));
            end
            if (ext_cycles != ((v.opcode == cpu_decode_pkg::CB_PREFIX) ? 3 : 0)) begin
                report_mismatch($sformatf("opcode %h %h ext high for %0d clocks",
                                          v.opcode, v.byte2, ext_cycles));
            end
        end
    endtask

    initial begin
        int          k;
        int          err0;
        int          rand_err0;
        logic [31:0] rng;
        logic [7:0]  next_op;

        errors      = 0;
        tests       = 0;
        hung        = 1'b0;
        rst         = 1'b0;
        data_bus_in = 8'h00;
        rng         = 32'd99187;
        rand_err0   = -1;
        for (k = 0; k < NUM_VEC; k++) begin
            order.push_back(k);
        end
        for (k = 0; k < NUM_RAND; k++) begin
            rng = xorshift(rng);
            order.push_back(int'(rng % NUM_VEC));
        end

        err0 = errors;
        check_reset(VECTORS[order[0]].opcode);
        tests++;
        $display("reset and first NOP: %s", (errors == err0) ? "ok" : "failed");

        for (k = 0; k < order.size() && !hung; k++) begin
            next_op = (k + 1 < order.size()) ? VECTORS[order[k + 1]].opcode : 8'h00;
            if (k == NUM_VEC) begin
                rand_err0 = errors;  // Random run is one test
            end
            err0 = errors;
            run_instr(VECTORS[order[k]], next_op);
            if (k < NUM_VEC) begin
                tests++;
                $display("row %0d opcode %h %h: %s", k, VECTORS[k].opcode, VECTORS[k].byte2,
                         (errors == err0) ? "ok" : "failed");
            end
        end
        if (rand_err0 >= 0) begin
            tests++;
            $display("random sequence of %0d rows: %s", NUM_RAND,
                     (errors == rand_err0) ? "ok" : "failed");
        end

        $display("tests %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- rtl/decode_top.sv
module decode_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [7:0]                data_bus_in,
    output cpu_decode_pkg::reg_ctrl_t reg_ctrl,
    output cpu_decode_pkg::alu_ctrl_t alu_ctrl,
    output cpu_decode_pkg::bus_ctrl_t bus_ctrl,
    output logic                      ext,
    output logic                      hold,
    output logic                      m1t1,
    output logic [1:0]                m_cycle,
    output logic [1:0]                t_cycle
);

    logic [1:0]                m_count;
    logic                      last_m;
    logic [7:0]                instruction;
    cpu_decode_pkg::micro_op_t micro_op;

    cycle_timer u_timer (
        .clk     (clk),
        .rst     (rst),
        .m_count (m_count),
        .m_cycle (m_cycle),
        .t_cycle (t_cycle),
        .m1t1    (m1t1),
        .last_m  (last_m),
        .hold    (hold)
    );

    instr_reg u_ireg (
        .clk         (clk),
        .rst         (rst),
        .data_bus_in (data_bus_in),
        .m1t1        (m1t1),
        .m_cycle     (m_cycle),
        .t_cycle     (t_cycle),
        .instruction (instruction),
        .ext         (ext)
    );

    op_decoder u_dec (
        .instruction (instruction),
        .ext         (ext),
        .m_cycle     (m_cycle),
        .m_count     (m_count),
        .micro_op    (micro_op)
    );

    strobe_gen u_strobe (
        .micro_op (micro_op),
        .t_cycle  (t_cycle),
        .last_m   (last_m),
        .reg_ctrl (reg_ctrl),
        .alu_ctrl (alu_ctrl),
        .bus_ctrl (bus_ctrl)
    );

endmodule

//--- rtl/strobe_gen.sv
module strobe_gen (
    input  cpu_decode_pkg::micro_op_t micro_op,
    input  logic [1:0]                t_cycle,
    input  logic                      last_m,
    output cpu_decode_pkg::reg_ctrl_t reg_ctrl,
    output cpu_decode_pkg::alu_ctrl_t alu_ctrl,
    output cpu_decode_pkg::bus_ctrl_t bus_ctrl
);

    logic t1;
    logic t3;
    logic fetch;  // Next opcode read overlaps the last M-cycle

    assign t1    = (t_cycle == 2'd0);
    assign t3    = (t_cycle == 2'd2);
    assign fetch = last_m && !micro_op.mem_read && !micro_op.mem_write;

    always_comb begin
        bus_ctrl.rd = t3 && (micro_op.mem_read || last_m);
        bus_ctrl.wr = t3 && micro_op.mem_write;
    end

    always_comb begin
        reg_ctrl.rd_en     = micro_op.rd_en;
        reg_ctrl.wr_en     = micro_op.reg_write && t_cycle[1];  // T3 and T4
        reg_ctrl.rd_addr   = micro_op.rd_addr;
        reg_ctrl.wr_addr   = micro_op.wr_addr;
        reg_ctrl.src_sel   = micro_op.src_sel;
        reg_ctrl.inc_pc    = micro_op.inc_pc && t1;
        reg_ctrl.writeback = (t_cycle == 2'd3);

        // PC goes out for the opcode fetch
        if (fetch) begin
            reg_ctrl.mem_addr_sel = cpu_decode_pkg::ADDR_PC;
            reg_ctrl.drive_addr   = 1'b1;
        end else begin
            reg_ctrl.mem_addr_sel = micro_op.addr_sel;
            reg_ctrl.drive_addr   = micro_op.drive_addr;
        end
    end

    always_comb begin
        alu_ctrl.go        = micro_op.alu_go && t3;
        alu_ctrl.op        = micro_op.alu_op;
        alu_ctrl.src_sel   = micro_op.alu_src_sel;
        alu_ctrl.bit_index = micro_op.bit_index;
        alu_ctrl.incdec    = micro_op.incdec;
        alu_ctrl.misc      = micro_op.misc;
    end

    // A decoded memory access must never land on the fetch M-cycle
    always_comb begin
        a_rd_wr_excl : assert final (!(bus_ctrl.rd && bus_ctrl.wr))
            else $error("bus rd and wr both high at t_cycle %0d", t_cycle);
    end

endmodule

//--- rtl/op_decoder.sv
module op_decoder (
    input  logic [7:0]                instruction,
    input  logic                      ext,
    input  logic [1:0]                m_cycle,
    output logic [1:0]                m_count,
    output cpu_decode_pkg::micro_op_t micro_op
);

    logic [1:0] op_x;  // Opcode block [7:6]
    logic [2:0] op_y;  // Destination or ALU operation
    logic [2:0] op_z;  // Source register or sub-group
    logic [1:0] op_p;  // Register pair for LD rr,nn

    assign op_x = instruction[7:6];
    assign op_y = instruction[5:3];
    assign op_z = instruction[2:0];
    assign op_p = instruction[5:4];

    function automatic cpu_decode_pkg::micro_op_t read_mem(
        cpu_decode_pkg::micro_op_t u,
        cpu_decode_pkg::addr_sel_t sel
    );
        u.mem_read   = 1'b1;
        u.drive_addr = 1'b1;
        u.addr_sel   = sel;
        return u;
    endfunction

    function automatic cpu_decode_pkg::micro_op_t write_reg(
        cpu_decode_pkg::micro_op_t u,
        cpu_decode_pkg::reg_code_t dst,
        cpu_decode_pkg::src_sel_t  src
    );
        u.reg_write = 1'b1;
        u.wr_addr   = dst;
        u.src_sel   = src;
        return u;
    endfunction

    // Start the ALU with a register operand on the read port
    function automatic cpu_decode_pkg::micro_op_t use_alu(
        cpu_decode_pkg::micro_op_t u,
        logic [2:0]                op,
        cpu_decode_pkg::reg_code_t src
    );
        u.alu_go  = 1'b1;
        u.alu_op  = op;
        u.rd_en   = 1'b1;
        u.rd_addr = src;
        return u;
    endfunction

    always_comb begin
        micro_op          = '0;
        micro_op.addr_sel = cpu_decode_pkg::ADDR_PC;
        m_count           = 2'd1;  // Unknown opcodes run as NOP

        if (ext) begin
            // CB page, prefix fetch was M1
            m_count = 2'd2;
            if (m_cycle == 2'd1 && op_z != cpu_decode_pkg::MEM_HL) begin
                if (op_x == 2'b00) begin
                    micro_op = use_alu(micro_op, op_y, op_z);  // Rotates and shifts
                    micro_op = write_reg(micro_op, op_z, cpu_decode_pkg::SRC_ALU);
                end else begin
                    micro_op = use_alu(micro_op, {1'b0, op_x}, op_z);
                    micro_op.misc      = 1'b1;
                    micro_op.bit_index = op_y;
                    if (op_x != 2'b01) begin  // BIT only sets flags
                        micro_op = write_reg(micro_op, op_z, cpu_decode_pkg::SRC_ALU);
                    end
                end
            end
        end else begin
            case (op_x)
                2'b00: begin
                    case (op_z)
                        3'b001: begin
                            if (!op_y[0] && op_p != 2'b11) begin  // LD rr,nn, low byte first
                                m_count = 2'd3;
                                case (m_cycle)
                                    2'd0: micro_op = read_mem(micro_op, cpu_decode_pkg::ADDR_PC);
                                    2'd1: begin
                                        micro_op.inc_pc = 1'b1;
                                        micro_op = read_mem(micro_op, cpu_decode_pkg::ADDR_PC);
                                        micro_op = write_reg(micro_op, {op_p, 1'b1},
                                                             cpu_decode_pkg::SRC_MEM);
                                    end
                                    2'd2: begin
                                        micro_op.inc_pc = 1'b1;
                                        micro_op = write_reg(micro_op, {op_p, 1'b0},
                                                             cpu_decode_pkg::SRC_MEM);
                                    end
                                    default: ;
                                endcase
                            end
                        end
                        3'b100, 3'b101: begin
                            if (op_y != cpu_decode_pkg::MEM_HL) begin  // INC r, DEC r
                                micro_op = use_alu(micro_op, op_z, op_y);
                                micro_op.incdec = 1'b1;
                                micro_op = write_reg(micro_op, op_y, cpu_decode_pkg::SRC_ALU);
                            end
                        end
                        3'b110: begin
                            if (op_y != cpu_decode_pkg::MEM_HL) begin  // LD r,n
                                m_count = 2'd2;
                                if (m_cycle == 2'd0) begin
                                    micro_op = read_mem(micro_op, cpu_decode_pkg::ADDR_PC);
                                end else begin
                                    micro_op.inc_pc = 1'b1;
                                    micro_op = write_reg(micro_op, op_y, cpu_decode_pkg::SRC_MEM);
                                end
                            end
                        end
                        default: ;
                    endcase
                end
                2'b01: begin
                    if (op_y != cpu_decode_pkg::MEM_HL && op_z != cpu_decode_pkg::MEM_HL) begin
                        micro_op.rd_en   = 1'b1;  // LD r,r'
                        micro_op.rd_addr = op_z;
                        micro_op = write_reg(micro_op, op_y, cpu_decode_pkg::SRC_SBUS);
                    end else if (op_z != cpu_decode_pkg::MEM_HL) begin
                        m_count = 2'd2;  // LD (HL),r, M2 idle
                        if (m_cycle == 2'd0) begin
                            micro_op.mem_write  = 1'b1;
                            micro_op.drive_addr = 1'b1;
                            micro_op.addr_sel   = cpu_decode_pkg::ADDR_HL;
                            micro_op.rd_en      = 1'b1;
                            micro_op.rd_addr    = op_z;
                        end
                    end else if (op_y != cpu_decode_pkg::MEM_HL) begin
                        m_count = 2'd2;  // LD r,(HL)
                        if (m_cycle == 2'd0) begin
                            micro_op = read_mem(micro_op, cpu_decode_pkg::ADDR_HL);
                        end else begin
                            micro_op = write_reg(micro_op, op_y, cpu_decode_pkg::SRC_MEM);
                        end
                    end
                end
                2'b10: begin
                    if (op_z != cpu_decode_pkg::MEM_HL) begin
                        micro_op = use_alu(micro_op, op_y, op_z);
                        micro_op = write_reg(micro_op, cpu_decode_pkg::REG_A,
                                             cpu_decode_pkg::SRC_ALU);
                    end else begin
                        m_count = 2'd2;  // ALU A,(HL)
                        if (m_cycle == 2'd0) begin
                            micro_op = read_mem(micro_op, cpu_decode_pkg::ADDR_HL);
                        end else begin
                            micro_op = use_alu(micro_op, op_y, cpu_decode_pkg::REG_A);
                            micro_op.alu_src_sel = 1'b1;
                            micro_op = write_reg(micro_op, cpu_decode_pkg::REG_A,
                                                 cpu_decode_pkg::SRC_ALU);
                        end
                    end
                end
                default: begin
                    if (instruction == cpu_decode_pkg::CB_PREFIX) begin
                        m_count = 2'd2;
                        if (m_cycle == 2'd0) begin
                            micro_op = read_mem(micro_op, cpu_decode_pkg::ADDR_PC);
                        end else begin
                            micro_op.inc_pc = 1'b1;  // Step past the extension byte
                        end
                    end else if (op_z == 3'b110) begin
                        m_count = 2'd2;  // ALU A,n
                        if (m_cycle == 2'd0) begin
                            micro_op = read_mem(micro_op, cpu_decode_pkg::ADDR_PC);
                        end else begin
                            micro_op.inc_pc = 1'b1;
                            micro_op = use_alu(micro_op, op_y, cpu_decode_pkg::REG_A);
                            micro_op.alu_src_sel = 1'b1;
                            micro_op = write_reg(micro_op, cpu_decode_pkg::REG_A,
                                                 cpu_decode_pkg::SRC_ALU);
                        end
                    end
                end
            endcase
        end
    end

endmodule

//--- rtl/instr_reg.sv
module instr_reg (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] data_bus_in,
    input  logic       m1t1,
    input  logic [1:0] m_cycle,
    input  logic [1:0] t_cycle,
    output logic [7:0] instruction,
    output logic       ext
);

    logic ext_load;

    // Second byte of a CB instruction arrives at M2 T1
    assign ext_load = !ext && (m_cycle == 2'd1) && (t_cycle == 2'd0) &&
                      (instruction == cpu_decode_pkg::CB_PREFIX);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            instruction <= 8'h00;  // NOP
            ext         <= 1'b0;
        end else if (m1t1) begin
            instruction <= data_bus_in;  // Opcode fetch
            ext         <= 1'b0;
        end else if (ext_load) begin
            instruction <= data_bus_in;
            ext         <= 1'b1;
        end
    end

    // The CB page runs in M2 only, ext drops with the next opcode fetch
    a_ext_in_m2 : assert property (
        @(posedge clk) disable iff (!rst)
        ext |-> (m_cycle == 2'd1) || m1t1
    ) else $error("ext high in M-cycle %0d T%0d", m_cycle + 1, t_cycle + 1);

endmodule

//--- rtl/cycle_timer.sv
module cycle_timer (
    input  logic       clk,
    input  logic       rst,
    input  logic [1:0] m_count,   // M-cycles in the current instruction
    output logic [1:0] m_cycle,
    output logic [1:0] t_cycle,
    output logic       m1t1,
    output logic       last_m,
    output logic       hold
);

    logic t_end;

    assign t_end  = (t_cycle == 2'(cpu_decode_pkg::T_PER_M - 1));  // T4
    assign last_m = (m_cycle == m_count - 2'd1);
    assign m1t1   = (m_cycle == 2'd0) && (t_cycle == 2'd0);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            m_cycle <= 2'd0;
            t_cycle <= 2'd0;
            hold    <= 1'b1;
        end else begin
            if (t_end) begin
                t_cycle <= 2'd0;
                hold    <= 1'b0;  // Released once the first M-cycle is done
                if (last_m) begin
                    m_cycle <= 2'd0;  // Instruction boundary
                end else begin
                    m_cycle <= m_cycle + 2'd1;
                end
            end else begin
                t_cycle <= t_cycle + 2'd1;
            end
        end
    end

    // Decoded length must always cover the running M-cycle,
    // otherwise the wrap at last_m would be skipped
    a_m_cycle_range : assert property (
        @(posedge clk) disable iff (!rst)
        (m_cycle < m_count) && (m_cycle < 2'(cpu_decode_pkg::MAX_M))
    ) else $error("m_cycle %0d out of range for m_count %0d", m_cycle, m_count);

endmodule

//--- rtl/cpu_decode_pkg.sv
package cpu_decode_pkg;

    // Register file codes, as found in opcode fields
    typedef logic [2:0] reg_code_t;

    localparam reg_code_t REG_B  = 3'd0;
    localparam reg_code_t REG_C  = 3'd1;
    localparam reg_code_t REG_D  = 3'd2;
    localparam reg_code_t REG_E  = 3'd3;
    localparam reg_code_t REG_H  = 3'd4;
    localparam reg_code_t REG_L  = 3'd5;
    localparam reg_code_t MEM_HL = 3'd6;  // Memory operand at (HL)
    localparam reg_code_t REG_A  = 3'd7;

    // Register file data source mux
    typedef logic [1:0] src_sel_t;

    localparam src_sel_t SRC_SBUS  = 2'b00;
    localparam src_sel_t SRC_ALU   = 2'b01;
    localparam src_sel_t SRC_MEM   = 2'b10;
    localparam src_sel_t SRC_DEBUG = 2'b11;

    // 16-bit address source in the register file
    typedef logic [2:0] addr_sel_t;

    localparam addr_sel_t ADDR_PC = 3'b000;
    localparam addr_sel_t ADDR_BC = 3'b100;
    localparam addr_sel_t ADDR_DE = 3'b101;
    localparam addr_sel_t ADDR_HL = 3'b110;

    localparam int T_PER_M = 4;  // T-cycles in one M-cycle
    localparam int MAX_M   = 3;  // Longest kept instruction, LD rr,nn

    localparam logic [7:0] CB_PREFIX = 8'hCB;

    // One M-cycle worth of work, before T-cycle gating
    typedef struct packed {
        logic      mem_read;
        logic      mem_write;
        logic      reg_write;
        logic      alu_go;
        logic      inc_pc;
        logic      rd_en;
        reg_code_t rd_addr;
        reg_code_t wr_addr;
        src_sel_t  src_sel;
        addr_sel_t addr_sel;
        logic      drive_addr;
        logic [2:0] alu_op;
        logic      alu_src_sel;   // 1 selects the memory data byte
        logic [2:0] bit_index;
        logic      incdec;
        logic      misc;          // Bit operations on the CB page
    } micro_op_t;

    typedef struct packed {
        logic      rd_en;
        logic      wr_en;
        reg_code_t rd_addr;
        reg_code_t wr_addr;
        src_sel_t  src_sel;
        addr_sel_t mem_addr_sel;
        logic      drive_addr;
        logic      inc_pc;
        logic      writeback;
    } reg_ctrl_t;

    typedef struct packed {
        logic       go;
        logic [2:0] op;
        logic       src_sel;
        logic [2:0] bit_index;
        logic       incdec;
        logic       misc;
    } alu_ctrl_t;

    typedef struct packed {
        logic rd;
        logic wr;
    } bus_ctrl_t;

endpackage
